//--- Makefile
# Verilator build and run of the cache request generator testbench

TOP := tb_cache_request_generator
SHELL := /bin/bash

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): tb.f $(wildcard hdl/*.sv sim/*.sv)
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f tb.f

# A nonzero simulator exit or the fail message in the log fails the run
run: compile
	set -o pipefail; ./obj_dir/V$(TOP) | tee sim.log
	@if grep -q "TEST FAILED" sim.log; then exit 1; fi

clean:
	rm -rf obj_dir sim.log

//--- hdl/cache_req_pkg.sv
// Shared types and sizes for the read-only cache request path
// Two requestors only, and the arbiter relies on that
// FIFO depth must stay a power of two for pointer wrap
`default_nettype none

package cache_req_pkg;

  // ------------------------------
  // Sizes
  // ------------------------------

  // Memory requestors in front of the arbiter
  localparam int num_requestors = 2;

  // Byte address width
  localparam int addr_width = 32;

  // Request FIFO
  localparam int fifo_depth = 32;
  localparam int fifo_ptr_width = $clog2(fifo_depth);
  // One extra bit so a full FIFO is distinct from empty
  localparam int fifo_count_width = fifo_ptr_width + 1;

  // Outstanding cache reads
  localparam int credit_max = 16;
  localparam int credit_width = 5;

  // ------------------------------
  // Request structs
  // ------------------------------

  // Requestor input, valid is a single-cycle strobe
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] base_address;
    logic [addr_width-1:0] address_offset;
  } mem_request_t;

  // One cache read, req_id names the requestor
  typedef struct packed {
    logic                  valid;
    logic [addr_width-1:0] addr;
    logic                  req_id;
  } cache_request_t;

  // Stored FIFO word, addr and req_id only
  localparam int cache_payload_width = $bits(cache_request_t) - 1;

  // ------------------------------
  // Issue FSM
  // ------------------------------
  typedef enum logic [2:0] {
    issue_reset,
    issue_idle,
    issue_fetch,
    issue_load,
    issue_busy
  } issue_state_t;

endpackage

`default_nettype wire

//--- hdl/cache_request_generator.sv
// Cache read generator for two memory requestors, reads only
// Each port strobes at most every second cycle, no back-pressure
// overflow is sticky until reset and marks a lost request
`default_nettype none

module cache_request_generator (
  input  wire logic                        ap_clk,
  input  wire logic                        control_areset,
  input  wire cache_req_pkg::mem_request_t mem_req_in [cache_req_pkg::num_requestors],
  output cache_req_pkg::cache_request_t    cache_req_out,
  input  wire logic                        cache_ready,
  input  wire logic                        cache_resp,
  output logic                             overflow
);

  cache_req_pkg::mem_request_t   mem_req_q [cache_req_pkg::num_requestors];
  cache_req_pkg::mem_request_t   grant;
  logic                          grant_id;
  logic                          arb_dropped;
  cache_req_pkg::cache_request_t fifo_din;
  cache_req_pkg::cache_request_t fifo_dout;
  logic                          fifo_dout_valid;
  logic                          fifo_rd_en;
  logic                          fifo_full;
  logic                          fifo_empty;
  logic                          resp_q;
  logic                          take;
  logic                          stall;

  // ------------------------------
  // Input registers
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      for (int i = 0; i < cache_req_pkg::num_requestors; i++) begin
        mem_req_q[i].valid <= 1'b0;
      end
    end else begin
      for (int i = 0; i < cache_req_pkg::num_requestors; i++) begin
        mem_req_q[i] <= mem_req_in[i];
      end
    end
  end

  request_arbiter i_request_arbiter (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .req_in        (mem_req_q),
    .grant_out     (grant),
    .grant_id      (grant_id),
    .dropped       (arb_dropped)
  );

  // ------------------------------
  // Address formation
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      fifo_din.valid <= 1'b0;
    end else begin
      fifo_din.valid <= grant.valid;
      // Cache address is base plus offset
      fifo_din.addr <= grant.base_address + grant.address_offset;
      // Tag with the winning port
      fifo_din.req_id <= grant_id;
    end
  end

  // ------------------------------
  // Overflow and response strobe
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      overflow <= 1'b0;
      resp_q <= 1'b0;
    end else begin
      resp_q <= cache_resp;
      // Slot collision or write into a full FIFO
      if (arb_dropped || (fifo_din.valid && fifo_full)) begin
        overflow <= 1'b1;
      end
    end
  end

  request_fifo i_request_fifo (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .wr_en         (fifo_din.valid),
    .din           (fifo_din),
    .rd_en         (fifo_rd_en),
    .dout          (fifo_dout),
    .dout_valid    (fifo_dout_valid),
    .full          (fifo_full),
    .empty         (fifo_empty)
  );

  // Returned credit usable two cycles after cache_resp
  credit_counter i_credit_counter (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .take          (take),
    .give          (resp_q),
    .stall         (stall)
  );

  issue_fsm i_issue_fsm (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .empty         (fifo_empty),
    .stall         (stall),
    .dout          (fifo_dout),
    .dout_valid    (fifo_dout_valid),
    .rd_en         (fifo_rd_en),
    .take          (take),
    .cache_ready   (cache_ready),
    .cache_req_out (cache_req_out)
  );

endmodule

`default_nettype wire

//--- hdl/credit_counter.sv
// Outstanding read credits, starts full at credit_max
// take and give together leave the count unchanged
`default_nettype none

module credit_counter (
  input  wire logic ap_clk,
  input  wire logic control_areset,
  input  wire logic take,
  input  wire logic give,
  output logic      stall
);

  logic [cache_req_pkg::credit_width-1:0] count;

  // ------------------------------
  // Credit count
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      count <= cache_req_pkg::credit_width'(cache_req_pkg::credit_max);
    end else begin
      case ({take, give})
        // Request issued
        2'b10:   count <= count - 1'b1;
        // Response back
        2'b01:   count <= count + 1'b1;
        default: count <= count;
      endcase
    end
  end

  // No credit left
  assign stall = (count == '0);

  // Issue side honours stall
  a_no_take_stalled: assert property (@(posedge ap_clk) disable iff (control_areset)
    !(take && stall));

  // Cache returns no more responses than reads
  a_no_give_full: assert property (@(posedge ap_clk) disable iff (control_areset)
    !(give && count == cache_req_pkg::credit_width'(cache_req_pkg::credit_max)));

endmodule

`default_nettype wire

//--- hdl/issue_fsm.sv
// Pops one FIFO entry at a time and holds it on the cache port
// A new pop waits until the held request is accepted
// Accept is valid and cache_ready high at the same edge
`default_nettype none

module issue_fsm (
  input  wire logic                          ap_clk,
  input  wire logic                          control_areset,
  input  wire logic                          empty,
  input  wire logic                          stall,
  input  wire cache_req_pkg::cache_request_t dout,
  input  wire logic                          dout_valid,
  output logic                               rd_en,
  output logic                               take,
  input  wire logic                          cache_ready,
  output cache_req_pkg::cache_request_t      cache_req_out
);

  cache_req_pkg::issue_state_t state;
  cache_req_pkg::issue_state_t next_state;
  logic                        pop;

  // ------------------------------
  // Pop decision
  // ------------------------------
  // Entry waiting and a credit free
  assign pop = (state == cache_req_pkg::issue_fetch) && !empty && !stall;
  assign rd_en = pop;
  // Credit spent at pop time
  assign take = pop;

  // ------------------------------
  // State register and next state
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      state <= cache_req_pkg::issue_reset;
    end else begin
      state <= next_state;
    end
  end

  always_comb begin
    next_state = state;
    case (state)
      cache_req_pkg::issue_reset: next_state = cache_req_pkg::issue_idle;
      cache_req_pkg::issue_idle:  next_state = cache_req_pkg::issue_fetch;
      cache_req_pkg::issue_fetch: begin
        if (pop) begin
          next_state = cache_req_pkg::issue_load;
        end
      end
      // Read data one cycle behind rd_en
      cache_req_pkg::issue_load: begin
        if (dout_valid) begin
          next_state = cache_req_pkg::issue_busy;
        end
      end
      cache_req_pkg::issue_busy: begin
        if (cache_ready) begin
          next_state = cache_req_pkg::issue_fetch;
        end
      end
      default: next_state = cache_req_pkg::issue_reset;
    endcase
  end

  // ------------------------------
  // Output hold register
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      cache_req_out.valid <= 1'b0;
    end else if (state == cache_req_pkg::issue_load && dout_valid) begin
      // dout.valid is set here
      cache_req_out <= dout;
    end else if (state == cache_req_pkg::issue_busy && cache_ready) begin
      cache_req_out.valid <= 1'b0;
    end
  end

  // Held request unchanged under back-pressure
  a_hold_stable: assert property (@(posedge ap_clk) disable iff (control_areset)
    cache_req_out.valid && !cache_ready |=> cache_req_out.valid && $stable(cache_req_out));

  // FIFO answers every pop on the next cycle
  a_pop_returns: assert property (@(posedge ap_clk) disable iff (control_areset)
    rd_en |=> dout_valid);

endmodule

`default_nettype wire

//--- hdl/request_arbiter.sv
// Round-robin between two ports, one pending slot each
// A fresh strobe bypasses an empty slot, so a winner takes one cycle
// A strobe into a full slot that is not served is lost and flagged
`default_nettype none

module request_arbiter (
  input  wire logic                        ap_clk,
  input  wire logic                        control_areset,
  input  wire cache_req_pkg::mem_request_t req_in [cache_req_pkg::num_requestors],
  output cache_req_pkg::mem_request_t      grant_out,
  output logic                             grant_id,
  output logic                             dropped
);

  cache_req_pkg::mem_request_t              slot [cache_req_pkg::num_requestors];
  cache_req_pkg::mem_request_t              cand [cache_req_pkg::num_requestors];
  logic [cache_req_pkg::num_requestors-1:0] granted;
  logic [cache_req_pkg::num_requestors-1:0] drop;
  logic                                     any_req;
  logic                                     win_id;
  logic                                     last_id;

  // ------------------------------
  // Candidate select
  // ------------------------------
  always_comb begin
    // Pending slot first, else the incoming strobe
    for (int i = 0; i < cache_req_pkg::num_requestors; i++) begin
      cand[i] = slot[i].valid ? slot[i] : req_in[i];
    end
    any_req = cand[0].valid | cand[1].valid;
    // Both contending, favour the port not served last
    if (cand[0].valid && cand[1].valid) begin
      win_id = ~last_id;
    end else begin
      win_id = cand[1].valid;
    end
    for (int i = 0; i < cache_req_pkg::num_requestors; i++) begin
      granted[i] = any_req && (win_id == i[0]);
      // Slot busy and not freed this cycle
      drop[i] = slot[i].valid && req_in[i].valid && !granted[i];
    end
  end

  // ------------------------------
  // Grant register and slots
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      grant_out.valid <= 1'b0;
      last_id <= 1'b0;
      dropped <= 1'b0;
      for (int i = 0; i < cache_req_pkg::num_requestors; i++) begin
        slot[i].valid <= 1'b0;
      end
    end else begin
      // Invalid candidate when nothing is requested
      grant_out <= cand[win_id];
      grant_id <= win_id;
      if (any_req) begin
        last_id <= win_id;
      end
      dropped <= |drop;
      for (int i = 0; i < cache_req_pkg::num_requestors; i++) begin
        if (slot[i].valid) begin
          // Served slot refills or empties
          if (granted[i]) begin
            slot[i] <= req_in[i];
          end
        end else if (req_in[i].valid && !granted[i]) begin
          // Loser parks here for a cycle
          slot[i] <= req_in[i];
        end
      end
    end
  end

  // A parked request that loses now wins on the next cycle
  a_slot0_served: assert property (@(posedge ap_clk) disable iff (control_areset)
    slot[0].valid && !granted[0] |=> granted[0]);

  a_slot1_served: assert property (@(posedge ap_clk) disable iff (control_areset)
    slot[1].valid && !granted[1] |=> granted[1]);

endmodule

`default_nettype wire

//--- hdl/request_fifo.sv
// Circular buffer of cache reads, fifo_depth entries
// Read data and dout_valid arrive one cycle after rd_en
// Writes while full and reads while empty are ignored
`default_nettype none

module request_fifo (
  input  wire logic                          ap_clk,
  input  wire logic                          control_areset,
  input  wire logic                          wr_en,
  input  wire cache_req_pkg::cache_request_t din,
  input  wire logic                          rd_en,
  output cache_req_pkg::cache_request_t      dout,
  output logic                               dout_valid,
  output logic                               full,
  output logic                               empty
);

  // Storage without the valid bit
  logic [cache_req_pkg::cache_payload_width-1:0] mem [cache_req_pkg::fifo_depth];
  logic [cache_req_pkg::cache_payload_width-1:0] rd_data;
  logic [cache_req_pkg::fifo_ptr_width-1:0]      wr_ptr;
  logic [cache_req_pkg::fifo_ptr_width-1:0]      rd_ptr;
  logic [cache_req_pkg::fifo_count_width-1:0]    count;
  logic                                          wr_ok;
  logic                                          rd_ok;

  // ------------------------------
  // Status
  // ------------------------------
  assign full = (count == cache_req_pkg::fifo_count_width'(cache_req_pkg::fifo_depth));
  assign empty = (count == '0);
  assign wr_ok = wr_en & ~full;
  assign rd_ok = rd_en & ~empty;

  // Valid field rebuilt from the read strobe
  assign dout = {dout_valid, rd_data};

  // ------------------------------
  // Pointers and count
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (control_areset) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count <= '0;
      dout_valid <= 1'b0;
    end else begin
      dout_valid <= rd_ok;
      // Pointers wrap at the power-of-two depth
      if (wr_ok) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (rd_ok) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({wr_ok, rd_ok})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: count <= count;
      endcase
    end
  end

  // ------------------------------
  // Storage
  // ------------------------------
  always_ff @(posedge ap_clk) begin
    if (wr_ok) begin
      mem[wr_ptr] <= {din.addr, din.req_id};
    end
    if (rd_ok) begin
      rd_data <= mem[rd_ptr];
    end
  end

  // Issue side must check empty before popping
  a_no_read_empty: assert property (@(posedge ap_clk) disable iff (control_areset)
    rd_en |-> !empty);

  a_count_bound: assert property (@(posedge ap_clk) disable iff (control_areset)
    count <= cache_req_pkg::fifo_depth);

endmodule

`default_nettype wire

//--- sim/tb_cache_request_generator.sv
// Self-checking testbench for the cache request generator
// Expected addresses follow base plus offset for every stimulus row
// Each phase starts from a drained DUT with all credits returned
`default_nettype none

module tb_cache_request_generator;

  timeunit 1ns;
  timeprecision 100ps;

  // Table rows per phase
  localparam int single_first = 0;
  localparam int single_last = 7;
  localparam int dual_first = 8;
  localparam int dual_last = 23;
  localparam int credit_first = 24;
  localparam int credit_last = 43;
  localparam int hold_first = 44;
  localparam int hold_last = 49;
  localparam int flood_first = 50;
  localparam int flood_last = 89;
  localparam int num_rows = 90;

  // One strobe, its expected address and the idle cycles after it
  typedef struct packed {
    logic                                 port;
    logic [cache_req_pkg::addr_width-1:0] base;
    logic [cache_req_pkg::addr_width-1:0] offset;
    logic [cache_req_pkg::addr_width-1:0] exp_addr;
    logic [3:0]                           gap;
  } stim_row_t;

  logic                          ap_clk;
  logic                          control_areset;
  cache_req_pkg::mem_request_t   mem_req_in [cache_req_pkg::num_requestors];
  cache_req_pkg::cache_request_t cache_req_out;
  logic                          cache_ready;
  logic                          cache_resp;
  logic                          overflow;

  stim_row_t                            stim_table [num_rows];
  logic [cache_req_pkg::addr_width-1:0] exp_q [cache_req_pkg::num_requestors][$];
  cache_req_pkg::cache_request_t        held;
  int                                   seed;
  int                                   row_count;
  int                                   accepted;
  int                                   owed;
  int                                   resp_wait;
  int                                   resp_delay;
  int                                   resp_tokens;
  bit                                   resp_hold;
  int                                   checks;
  int                                   errors;
  int                                   phase_start;

  cache_request_generator i_cache_request_generator (
    .ap_clk        (ap_clk),
    .control_areset(control_areset),
    .mem_req_in    (mem_req_in),
    .cache_req_out (cache_req_out),
    .cache_ready   (cache_ready),
    .cache_resp    (cache_resp),
    .overflow      (overflow)
  );

  initial begin : clock_gen
    ap_clk = 1'b0;
    forever begin
      #50 ap_clk = ~ap_clk;
    end
  end

  // ------------------------------
  // Error reporting
  // ------------------------------
  task automatic flag_mismatch(input string what, input logic [31:0] got,
                               input logic [31:0] exp);
    errors++;
    $display("FAILED %0d ns: %s, got %h, expected %h", $time, what, got, exp);
  endtask

  task automatic flag_problem(input string what);
    errors++;
    $display("Error at %0d ns: %s", $time, what);
  endtask

  // ------------------------------
  // Stimulus table
  // ------------------------------
  task automatic add_row(input logic port, input logic [31:0] base, input logic [3:0] gap);
    stim_row_t row;
    row.port = port;
    row.base = base;
    row.offset = $random(seed);
    // Address rule, wraps at 32 bits
    row.exp_addr = base + row.offset;
    row.gap = gap;
    stim_table[row_count] = row;
    row_count++;
  endtask

  task automatic build_table();
    row_count = 0;
    // Single port, port 0 then port 1
    for (int i = 0; i < 8; i++) begin
      add_row(i >= 4, 32'h1000_0000 + 32'(i) * 32'h40, 4'd2);
    end
    // Both ports on one edge, every second cycle
    for (int i = 0; i < 16; i++) begin
      add_row(i[0], $random(seed), i[0] ? 4'd2 : 4'd0);
    end
    // Credit run on port 0
    for (int i = 0; i < 20; i++) begin
      add_row(1'b0, 32'h3000_0000 + 32'(i) * 32'h40, 4'd2);
    end
    // Ports take turns under back-pressure
    for (int i = 0; i < 6; i++) begin
      add_row(i[0], 32'hffff_ff00 + 32'(i) * 32'h10, 4'd1);
    end
    // Flood well past FIFO depth
    for (int i = 0; i < 40; i++) begin
      add_row(i[0], $random(seed), i[0] ? 4'd2 : 4'd0);
    end
  endtask

  // Rows sharing a zero gap strobe on the same falling edge
  task automatic apply_rows(input int first, input int last);
    int unsigned gap_cycles;
    @(negedge ap_clk);
    for (int i = first; i <= last; i++) begin
      mem_req_in[stim_table[i].port] = '{valid: 1'b1,
                                         base_address: stim_table[i].base,
                                         address_offset: stim_table[i].offset};
      exp_q[stim_table[i].port].push_back(stim_table[i].exp_addr);
      gap_cycles = stim_table[i].gap;
      if (gap_cycles != 0) begin
        @(negedge ap_clk);
        mem_req_in[0].valid = 1'b0;
        mem_req_in[1].valid = 1'b0;
        repeat (gap_cycles - 1) @(negedge ap_clk);
      end
    end
  endtask

  task automatic set_resp(input bit hold, input int tokens, input int delay);
    @(posedge ap_clk);
    resp_hold = hold;
    resp_tokens = tokens;
    resp_delay = delay;
  endtask

  task automatic wait_accepted(input int target);
    while (accepted < target) @(negedge ap_clk);
  endtask

  task automatic wait_drained();
    while (exp_q[0].size() != 0 || exp_q[1].size() != 0 || owed != 0) begin
      @(negedge ap_clk);
    end
    // Last credit lands two cycles after its response
    repeat (3) @(negedge ap_clk);
  endtask

  // ------------------------------
  // Scoreboard and cache model
  // ------------------------------
  always @(posedge ap_clk) begin : scoreboard
    logic [cache_req_pkg::addr_width-1:0] exp_addr;
    logic                                 id;
    if (!control_areset && cache_req_out.valid && cache_ready) begin
      accepted++;
      owed++;
      id = cache_req_out.req_id;
      checks++;
      assert (exp_q[id].size() > 0) else begin
        flag_problem($sformatf("port %0d delivered a request that was never sent", id));
      end
      if (exp_q[id].size() > 0) begin
        exp_addr = exp_q[id].pop_front();
        checks++;
        assert (cache_req_out.addr === exp_addr) else begin
          flag_mismatch($sformatf("port %0d cache address", id), cache_req_out.addr, exp_addr);
        end
      end
    end
  end

  // One response per accepted read, after resp_delay cycles
  initial begin : resp_driver
    cache_resp = 1'b0;
    forever begin
      @(negedge ap_clk);
      cache_resp = 1'b0;
      if (owed > 0 && (!resp_hold || resp_tokens > 0)) begin
        if (resp_wait < resp_delay) begin
          resp_wait++;
        end else begin
          cache_resp = 1'b1;
          owed--;
          resp_wait = 0;
          if (resp_hold) begin
            resp_tokens--;
          end
        end
      end
    end
  end

  initial begin : watchdog
    repeat (num_rows * 40) @(posedge ap_clk);
    $display("Watchdog expired after %0d cycles, the DUT stopped making progress",
             num_rows * 40);
    $display("TEST FAILED");
    $finish;
  end

  // ------------------------------
  // Test sequence
  // ------------------------------
  initial begin : main
    control_areset = 1'b1;
    cache_ready = 1'b1;
    mem_req_in[0] = '0;
    mem_req_in[1] = '0;
    seed = 32'h12cb;
    accepted = 0;
    owed = 0;
    resp_wait = 0;
    resp_delay = 2;
    resp_tokens = 0;
    resp_hold = 1'b0;
    checks = 0;
    errors = 0;
    build_table();
    repeat (4) @(negedge ap_clk);
    control_areset = 1'b0;

    // Quiet outputs before any request
    repeat (4) begin
      @(negedge ap_clk);
      checks++;
      assert (cache_req_out.valid === 1'b0 && overflow === 1'b0) else begin
        flag_mismatch("valid and overflow after reset",
                      32'({cache_req_out.valid, overflow}), 0);
      end
    end

    // One port at a time, then both together
    apply_rows(single_first, single_last);
    wait_drained();
    apply_rows(dual_first, dual_last);
    wait_drained();
    checks++;
    assert (overflow === 1'b0) else flag_mismatch("overflow after dual ports", 32'(overflow), 0);

    // Withheld responses cap the reads at credit_max
    set_resp(1'b1, 0, 3);
    phase_start = accepted;
    apply_rows(credit_first, credit_last);
    wait_accepted(phase_start + cache_req_pkg::credit_max);
    repeat (20) @(negedge ap_clk);
    checks++;
    assert (accepted == phase_start + cache_req_pkg::credit_max) else begin
      flag_mismatch("reads accepted without credits", accepted,
                    phase_start + cache_req_pkg::credit_max);
    end
    for (int k = 1; k <= 4; k++) begin
      set_resp(1'b1, 1, 3);
      wait_accepted(phase_start + cache_req_pkg::credit_max + k);
      repeat (10) @(negedge ap_clk);
      checks++;
      assert (accepted == phase_start + cache_req_pkg::credit_max + k) else begin
        flag_mismatch("reads accepted per returned credit", accepted,
                      phase_start + cache_req_pkg::credit_max + k);
      end
    end
    set_resp(1'b0, 0, 2);
    wait_drained();

    // Back-pressure holds the output steady
    @(negedge ap_clk);
    cache_ready = 1'b0;
    apply_rows(hold_first, hold_last);
    while (cache_req_out.valid !== 1'b1) @(negedge ap_clk);
    held = cache_req_out;
    repeat (12) begin
      @(negedge ap_clk);
      checks++;
      assert (cache_req_out === held) else begin
        flag_mismatch("held cache address", cache_req_out.addr, held.addr);
      end
    end
    cache_ready = 1'b1;
    wait_drained();
    checks++;
    assert (overflow === 1'b0) else flag_mismatch("overflow after hold", 32'(overflow), 0);

    // Flood with the cache stalled, output plus FIFO survive
    @(negedge ap_clk);
    cache_ready = 1'b0;
    phase_start = accepted;
    apply_rows(flood_first, flood_last);
    while (overflow !== 1'b1) @(negedge ap_clk);
    repeat (5) @(negedge ap_clk);
    cache_ready = 1'b1;
    wait_accepted(phase_start + cache_req_pkg::fifo_depth + 1);
    repeat (20) @(negedge ap_clk);
    checks++;
    assert (overflow === 1'b1) else flag_mismatch("sticky overflow", 32'(overflow), 1);
    checks++;
    assert (accepted == phase_start + cache_req_pkg::fifo_depth + 1) else begin
      flag_mismatch("reads surviving the flood", accepted,
                    phase_start + cache_req_pkg::fifo_depth + 1);
    end
    checks++;
    assert (exp_q[0].size() + exp_q[1].size() ==
            flood_last - flood_first + 1 - cache_req_pkg::fifo_depth - 1) else begin
      flag_mismatch("requests lost in the flood", exp_q[0].size() + exp_q[1].size(),
                    flood_last - flood_first + 1 - cache_req_pkg::fifo_depth - 1);
    end

    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- tb.f
hdl/cache_req_pkg.sv
hdl/request_arbiter.sv
hdl/request_fifo.sv
hdl/credit_counter.sv
hdl/issue_fsm.sv
hdl/cache_request_generator.sv
sim/tb_cache_request_generator.sv
